/* common/cache_pkg.sv */
package cache_pkg;

  // CPU word and byte address
  localparam int WORD_WIDTH = 32;
  localparam int ADDRESS_WIDTH = 32;

  // Line geometry
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_WIDTH = 128;

  // Address fields, tag on top, then word offset, then byte offset
  localparam int TAG_LSB = 4;
  localparam int WORD_OFFSET_LSB = 2;
  localparam int BYTE_OFFSET_LSB = 0;
  localparam int TAG_WIDTH = ADDRESS_WIDTH - TAG_LSB;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;

  // One cache line, seen as the flat memory bus or as its words
  // Word 0 sits in the low bits
  typedef union packed {
    logic [LINE_WIDTH-1:0] bits;
    word_t [WORDS_PER_LINE-1:0] words;
  } line_u;

  // CPU op bit
  localparam logic OP_WRITE = 1'b0;
  localparam logic OP_READ = 1'b1;

  // Memory op bit
  localparam logic MEM_OP_READ = 1'b0;
  localparam logic MEM_OP_WRITE = 1'b1;

endpackage

/* cache/cache_tag_match.sv */
`timescale 1ns/1ns

module cache_tag_match #(
  parameter int NUM_LINES = 4
) (
  input  cache_pkg::tag_t [NUM_LINES-1:0] tags,
  input  cache_pkg::tag_t                 tag,
  input  logic [NUM_LINES-1:0]            valid,
  output logic                            hit,
  output logic [$clog2(NUM_LINES)-1:0]    hit_line
);

  localparam int LINE_BITS = $clog2(NUM_LINES);

  logic [NUM_LINES-1:0] match;

  // One comparator per line, only valid lines may match
  always_comb
  begin
    for (int i = 0; i < NUM_LINES; i++)
    begin
      match[i] = valid[i] && (tags[i] == tag);
    end
  end

  assign hit = |match;

  // Priority encoder, lowest matching line wins
  // Scanning downwards lets the last assignment be the lowest index
  always_comb
  begin
    hit_line = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (match[i])
      begin
        hit_line = LINE_BITS'(i);
      end
    end
  end

endmodule

/* cache/cache_lru.sv */
`timescale 1ns/1ns

module cache_lru #(
  parameter int NUM_LINES = 4
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         touch,
  input  logic [$clog2(NUM_LINES)-1:0] touch_line,
  output logic [$clog2(NUM_LINES)-1:0] victim_line
);

  localparam int LINE_BITS = $clog2(NUM_LINES);

  // Counter NUM_LINES-1 is the most recently used line
  logic [LINE_BITS-1:0] counters [NUM_LINES];
  logic [LINE_BITS-1:0] lowest;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
        counters[i] <= LINE_BITS'(i);
      end
    end
    else if (touch)
    begin
      // Lines newer than the touched one age by one step
      for (int i = 0; i < NUM_LINES; i++)
      begin
        if (counters[i] >= counters[touch_line])
        begin
          counters[i] <= counters[i] - 1'b1;
        end
      end
      counters[touch_line] <= LINE_BITS'(NUM_LINES - 1);
    end
  end

  // Victim is the line holding the lowest counter
  always_comb
  begin
    victim_line = '0;
    lowest = counters[0];
    for (int i = 1; i < NUM_LINES; i++)
    begin
      if (counters[i] < lowest)
      begin
        lowest = counters[i];
        victim_line = LINE_BITS'(i);
      end
    end
  end

endmodule

/* cache/cache_core.sv */
`timescale 1ns/1ns

module cache_core #(
  parameter int NUM_LINES = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                access,
  input  logic                                op,
  input  logic                                byte_op,
  input  logic [cache_pkg::ADDRESS_WIDTH-1:0] address,
  input  cache_pkg::word_t                    data_in,
  output cache_pkg::word_t                    data_out,
  output logic                                data_ready,
  output logic                                mem_enable,
  output logic                                mem_op,
  output logic [cache_pkg::ADDRESS_WIDTH-1:0] mem_address,
  output cache_pkg::line_u                    mem_data_in,
  input  logic                                mem_data_ready,
  input  cache_pkg::line_u                    mem_data_out
);

  import cache_pkg::*;

  localparam int LINE_BITS = $clog2(NUM_LINES);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] WRITE_BACK = 2'd1;
  localparam logic [1:0] FETCH = 2'd2;
  localparam logic [1:0] RESPOND = 2'd3;

  logic [1:0] state;

  // Line storage
  tag_t [NUM_LINES-1:0] tag_array;
  line_u data_array [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] dirty;

  logic hit;
  logic [LINE_BITS-1:0] hit_line;
  logic [LINE_BITS-1:0] victim_line;
  logic [LINE_BITS-1:0] touch_line;
  logic accept;
  logic fill_done;
  logic touch;

  // Fields of the incoming address
  logic [TAG_LSB-WORD_OFFSET_LSB-1:0] word_sel;
  logic [WORD_OFFSET_LSB-BYTE_OFFSET_LSB-1:0] byte_sel;

  // Request held over a miss
  tag_t req_tag;
  logic req_op;
  logic req_byte;
  word_t req_data;
  logic [TAG_LSB-WORD_OFFSET_LSB-1:0] req_word;
  logic [WORD_OFFSET_LSB-BYTE_OFFSET_LSB-1:0] req_sel;
  logic [LINE_BITS-1:0] req_line;

  line_u fill_line;

  function automatic word_t merge_word(word_t old_word, word_t new_data, logic is_byte,
                                       logic [WORD_OFFSET_LSB-BYTE_OFFSET_LSB-1:0] sel);
    word_t result;
    result = new_data;
    if (is_byte)
    begin
      result = old_word;
      result[sel*8 +: 8] = new_data[7:0];
    end
    return result;
  endfunction

  // Byte reads come back zero-extended
  function automatic word_t read_word(word_t stored, logic is_byte,
                                      logic [WORD_OFFSET_LSB-BYTE_OFFSET_LSB-1:0] sel);
    return is_byte ? {24'b0, stored[sel*8 +: 8]} : stored;
  endfunction

  assign word_sel = address[TAG_LSB-1:WORD_OFFSET_LSB];
  assign byte_sel = address[WORD_OFFSET_LSB-1:BYTE_OFFSET_LSB];

  cache_tag_match #(
    .NUM_LINES(NUM_LINES)
  ) tag_match (
    .tags(tag_array),
    .tag(address[ADDRESS_WIDTH-1:TAG_LSB]),
    .valid(valid),
    .hit(hit),
    .hit_line(hit_line)
  );

  cache_lru #(
    .NUM_LINES(NUM_LINES)
  ) lru (
    .clk(clk),
    .reset(reset),
    .touch(touch),
    .touch_line(touch_line),
    .victim_line(victim_line)
  );

  // RESPOND is the data_ready cycle and takes a new access like IDLE
  assign accept = access && (state == IDLE || state == RESPOND);
  assign fill_done = (state == FETCH) && mem_enable && mem_data_ready;
  assign touch = (accept && hit) || fill_done;
  assign touch_line = fill_done ? req_line : hit_line;
  assign data_ready = (state == RESPOND);

  // Fetched line with a pending write already merged in
  always_comb
  begin
    fill_line = mem_data_out;
    if (req_op == OP_WRITE)
    begin
      fill_line.words[req_word] = merge_word(mem_data_out.words[req_word], req_data,
                                             req_byte, req_sel);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= IDLE;
      valid <= '0;
      dirty <= '0;
      mem_enable <= 1'b0;
      mem_op <= MEM_OP_READ;
      mem_address <= '0;
    end
    else
    begin
      case (state)
        IDLE, RESPOND:
        begin
          state <= IDLE;
          if (access)
          begin
            if (hit)
            begin
              if (op == OP_WRITE)
              begin
                dirty[hit_line] <= 1'b1;
              end
              state <= RESPOND;
            end
            else if (valid[victim_line] && dirty[victim_line])
            begin
              mem_enable <= 1'b1;
              mem_op <= MEM_OP_WRITE;
              mem_address <= {tag_array[victim_line], {TAG_LSB{1'b0}}};
              state <= WRITE_BACK;
            end
            else
            begin
              mem_enable <= 1'b1;
              mem_op <= MEM_OP_READ;
              mem_address <= {address[ADDRESS_WIDTH-1:TAG_LSB], {TAG_LSB{1'b0}}};
              state <= FETCH;
            end
          end
        end
        WRITE_BACK:
        begin
          if (mem_data_ready)
          begin
            mem_enable <= 1'b0;
            state <= FETCH;
          end
        end
        FETCH:
        begin
          // Coming from a write-back the enable is low for one cycle
          if (!mem_enable)
          begin
            mem_enable <= 1'b1;
            mem_op <= MEM_OP_READ;
            mem_address <= {req_tag, {TAG_LSB{1'b0}}};
          end
          else if (mem_data_ready)
          begin
            mem_enable <= 1'b0;
            valid[req_line] <= 1'b1;
            dirty[req_line] <= (req_op == OP_WRITE);
            state <= RESPOND;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_tag <= address[ADDRESS_WIDTH-1:TAG_LSB];
      req_op <= op;
      req_byte <= byte_op;
      req_data <= data_in;
      req_word <= word_sel;
      req_sel <= byte_sel;
      req_line <= victim_line;
      if (hit)
      begin
        if (op == OP_WRITE)
        begin
          data_array[hit_line].words[word_sel] <=
            merge_word(data_array[hit_line].words[word_sel], data_in, byte_op, byte_sel);
        end
        else
        begin
          data_out <= read_word(data_array[hit_line].words[word_sel], byte_op, byte_sel);
        end
      end
      else
      begin
        mem_data_in <= data_array[victim_line];
      end
    end
    if (fill_done)
    begin
      data_array[req_line] <= fill_line;
      tag_array[req_line] <= req_tag;
      if (req_op == OP_READ)
      begin
        data_out <= read_word(fill_line.words[req_word], req_byte, req_sel);
      end
    end
  end

endmodule

/* logic/line_memory.sv */
`timescale 1ns/1ns

module line_memory #(
  parameter int MEM_LINES = 64,
  parameter int MEM_LATENCY = 3
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                mem_enable,
  input  logic                                mem_op,
  input  logic [cache_pkg::ADDRESS_WIDTH-1:0] mem_address,
  input  cache_pkg::line_u                    mem_data_in,
  output logic                                mem_data_ready,
  output cache_pkg::line_u                    mem_data_out
);

  import cache_pkg::*;

  localparam int INDEX_BITS = $clog2(MEM_LINES);

  line_u mem [MEM_LINES];
  logic [INDEX_BITS-1:0] index;
  logic [$clog2(MEM_LATENCY+1)-1:0] count;
  logic done;

  // Low half is the address, high half its inverse
  function automatic word_t pattern_word(logic [ADDRESS_WIDTH-1:0] byte_address);
    return {~byte_address[15:0], byte_address[15:0]};
  endfunction

  initial
  begin
    for (int i = 0; i < MEM_LINES; i++)
      for (int w = 0; w < WORDS_PER_LINE; w++)
        mem[i].words[w] = pattern_word(ADDRESS_WIDTH'(i * (LINE_WIDTH / 8) + w * (WORD_WIDTH / 8)));
  end

  // Upper address bits wrap around the depth
  assign index = mem_address[TAG_LSB +: INDEX_BITS];
  assign done = mem_enable && !mem_data_ready && (count == MEM_LATENCY - 1);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count <= '0;
      mem_data_ready <= 1'b0;
    end
    else
    begin
      mem_data_ready <= done;
      if (mem_enable && !mem_data_ready && !done)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  always @(posedge clk)
  begin
    if (done)
    begin
      if (mem_op == MEM_OP_WRITE)
        mem[index] <= mem_data_in;
      else
        mem_data_out <= mem[index];
    end
  end

endmodule

/* logic/cache_system.sv */
`timescale 1ns/1ns

module cache_system #(
  parameter int NUM_LINES = 4,
  parameter int MEM_LATENCY = 3,
  parameter int MEM_LINES = 64
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                access,
  input  logic                                op,
  input  logic                                byte_op,
  input  logic [cache_pkg::ADDRESS_WIDTH-1:0] address,
  input  cache_pkg::word_t                    data_in,
  output cache_pkg::word_t                    data_out,
  output logic                                data_ready,
  output logic                                mem_enable,
  output logic                                mem_op,
  output logic [cache_pkg::ADDRESS_WIDTH-1:0] mem_address,
  output cache_pkg::line_u                    mem_data_in
);

  import cache_pkg::*;

  // Return path from the backing memory
  logic mem_data_ready;
  line_u mem_data_out;

  cache_core #(
    .NUM_LINES(NUM_LINES)
  ) core (
    .clk(clk),
    .reset(reset),
    .access(access),
    .op(op),
    .byte_op(byte_op),
    .address(address),
    .data_in(data_in),
    .data_out(data_out),
    .data_ready(data_ready),
    .mem_enable(mem_enable),
    .mem_op(mem_op),
    .mem_address(mem_address),
    .mem_data_in(mem_data_in),
    .mem_data_ready(mem_data_ready),
    .mem_data_out(mem_data_out)
  );

  line_memory #(
    .MEM_LINES(MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) memory (
    .clk(clk),
    .reset(reset),
    .mem_enable(mem_enable),
    .mem_op(mem_op),
    .mem_address(mem_address),
    .mem_data_in(mem_data_in),
    .mem_data_ready(mem_data_ready),
    .mem_data_out(mem_data_out)
  );

endmodule

/* tests/cache_system_assertions.sv */
`timescale 1ns/1ns

module cache_system_assertions (
  input logic                                clk,
  input logic                                reset,
  input logic                                access,
  input logic                                data_ready,
  input logic                                mem_enable,
  input logic                                mem_op,
  input logic [cache_pkg::ADDRESS_WIDTH-1:0] mem_address,
  input cache_pkg::line_u                    mem_data_in,
  input logic                                mem_data_ready
);

  import cache_pkg::*;

  tag_t request_tag;
  logic waiting;
  int failures = 0;

  assign request_tag = mem_address[ADDRESS_WIDTH-1:TAG_LSB];

  // An access stays outstanding from its strobe until data_ready
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      waiting <= 1'b0;
    end
    else if (access)
    begin
      waiting <= 1'b1;
    end
    else if (data_ready)
    begin
      waiting <= 1'b0;
    end
  end

  ready_pulse: assert property (@(posedge clk) disable iff (reset)
    data_ready |=> !data_ready)
    else
    begin
      $error("data_ready was high for more than one cycle");
      failures++;
    end

  // Write data only matters for a write-back
  // The low address bits are covered by line_aligned
  request_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_enable && !mem_data_ready) |=> mem_enable && $stable(mem_op) && $stable(request_tag)
      && (mem_op == MEM_OP_READ || $stable(mem_data_in)))
    else
    begin
      $error("memory request changed before mem_data_ready");
      failures++;
    end

  line_aligned: assert property (@(posedge clk) disable iff (reset)
    mem_enable |-> (mem_address[TAG_LSB-1:0] == '0))
    else
    begin
      $error("mem_address is not line-aligned");
      failures++;
    end

  no_early_access: assert property (@(posedge clk) disable iff (reset)
    (access && waiting) |-> data_ready)
    else
    begin
      $error("access arrived while a request was still in progress");
      failures++;
    end

endmodule

bind cache_system cache_system_assertions checks (
  .clk(clk),
  .reset(reset),
  .access(access),
  .data_ready(data_ready),
  .mem_enable(mem_enable),
  .mem_op(mem_op),
  .mem_address(mem_address),
  .mem_data_in(mem_data_in),
  .mem_data_ready(mem_data_ready)
);

/* tests/cache_system_tb.sv */
`timescale 1ns/1ns

module cache_system_tb;

  import cache_pkg::*;

  localparam int NUM_LINES = 4;
  localparam int MEM_LATENCY = 3;
  localparam int MEM_LINES = 64;
  localparam int CLK_PERIOD = 20;
  localparam int RANDOM_ACCESSES = 200;
  localparam int RANDOM_LINES = 12;
  localparam int NUM_ACCESSES = RANDOM_ACCESSES + 40;
  localparam int MAX_WAIT = 4 * MEM_LATENCY + 10;
  localparam int WATCHDOG_CYCLES = NUM_ACCESSES * (2 * MEM_LATENCY + 6) + 500;
  localparam logic [31:0] SEED = 32'h1fcf_913c;

  logic clk;
  logic reset;
  logic access;
  logic op;
  logic byte_op;
  logic [ADDRESS_WIDTH-1:0] address;
  word_t data_in;
  word_t data_out;
  logic data_ready;
  logic mem_enable;
  logic mem_op;
  logic [ADDRESS_WIDTH-1:0] mem_address;
  line_u mem_data_in;

  // Shadow of the memory contents as the CPU sees them
  word_t shadow_mem [MEM_LINES*WORDS_PER_LINE];
  // Shadow of cache residency
  tag_t model_tag [NUM_LINES];
  logic model_valid [NUM_LINES];
  logic model_dirty [NUM_LINES];
  int model_count [NUM_LINES];

  string test_name;
  int value_errors;
  int handshake_errors;

  // What the last access showed
  int last_latency;
  logic last_hit;
  logic last_wb_seen;
  logic last_fetch_seen;
  logic [ADDRESS_WIDTH-1:0] last_wb_address;
  logic [ADDRESS_WIDTH-1:0] last_fetch_address;
  line_u last_wb_line;
  word_t last_data;

  cache_system #(
    .NUM_LINES(NUM_LINES),
    .MEM_LATENCY(MEM_LATENCY),
    .MEM_LINES(MEM_LINES)
  ) uut (
    .clk(clk),
    .reset(reset),
    .access(access),
    .op(op),
    .byte_op(byte_op),
    .address(address),
    .data_in(data_in),
    .data_out(data_out),
    .data_ready(data_ready),
    .mem_enable(mem_enable),
    .mem_op(mem_op),
    .mem_address(mem_address),
    .mem_data_in(mem_data_in)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  // Low half holds the byte address, high half its inverse
  function automatic word_t pattern_at(logic [ADDRESS_WIDTH-1:0] byte_address);
    return {~byte_address[15:0], byte_address[15:0]};
  endfunction

  function automatic int word_index(logic [ADDRESS_WIDTH-1:0] byte_address);
    return int'(byte_address >> WORD_OFFSET_LSB) % (MEM_LINES * WORDS_PER_LINE);
  endfunction

  task automatic check_word(string what, word_t expected, word_t actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_line(string what, line_u expected, line_u actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what,
               expected.bits, actual.bits);
    end
  endtask

  task automatic check_address(string what, logic [ADDRESS_WIDTH-1:0] expected,
                               logic [ADDRESS_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_flag(string what, logic expected, logic actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("[ERROR] %s: %s expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic check_count(string what, int expected, int actual);
    if (actual != expected)
    begin
      value_errors++;
      $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic reset_model();
    for (int w = 0; w < MEM_LINES * WORDS_PER_LINE; w++)
    begin
      shadow_mem[w] = pattern_at(ADDRESS_WIDTH'(w * (WORD_WIDTH / 8)));
    end
    for (int i = 0; i < NUM_LINES; i++)
    begin
      model_valid[i] = 1'b0;
      model_dirty[i] = 1'b0;
      model_count[i] = i;
    end
  endtask

  // The touched line becomes newest, newer lines age by one
  task automatic touch_model(int line);
    int base;
    base = model_count[line];
    for (int i = 0; i < NUM_LINES; i++)
    begin
      if (model_count[i] >= base)
      begin
        model_count[i]--;
      end
    end
    model_count[line] = NUM_LINES - 1;
  endtask

  task automatic run_access(logic acc_op, logic acc_byte, logic [ADDRESS_WIDTH-1:0] a,
                            word_t d);
    tag_t t;
    int line;
    int hit_line;
    int idx;
    int sel;
    logic predict_wb;
    logic [ADDRESS_WIDTH-1:0] wb_address;
    line_u wb_line;
    word_t expected;
    t = a[ADDRESS_WIDTH-1:TAG_LSB];
    hit_line = -1;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (model_valid[i] && model_tag[i] == t)
      begin
        hit_line = i;
      end
    end
    line = 0;
    for (int i = 1; i < NUM_LINES; i++)
    begin
      if (model_count[i] < model_count[line])
      begin
        line = i;
      end
    end
    predict_wb = (hit_line < 0) && model_valid[line] && model_dirty[line];
    wb_address = {model_tag[line], {TAG_LSB{1'b0}}};
    for (int k = 0; k < WORDS_PER_LINE; k++)
    begin
      wb_line.words[k] = shadow_mem[word_index(wb_address) + k];
    end

    @(posedge clk);
    access <= 1'b1;
    op <= acc_op;
    byte_op <= acc_byte;
    address <= a;
    data_in <= d;
    @(posedge clk);
    access <= 1'b0;
    last_latency = 0;
    last_wb_seen = 1'b0;
    last_fetch_seen = 1'b0;
    do
    begin
      @(negedge clk);
      last_latency++;
      if (mem_enable && mem_op == MEM_OP_WRITE && !last_wb_seen)
      begin
        last_wb_seen = 1'b1;
        last_wb_address = mem_address;
        last_wb_line = mem_data_in;
      end
      if (mem_enable && mem_op == MEM_OP_READ && !last_fetch_seen)
      begin
        last_fetch_seen = 1'b1;
        last_fetch_address = mem_address;
      end
    end
    while (!data_ready && last_latency < MAX_WAIT);
    last_data = data_out;
    if (!data_ready)
    begin
      handshake_errors++;
      $display("%s: data_ready did not arrive within %0d cycles of access at %h",
               test_name, MAX_WAIT, a);
    end

    last_hit = (hit_line >= 0);
    if (last_hit)
    begin
      check_count("hit latency", 1, last_latency);
      check_flag("memory activity on hit", 1'b0, last_wb_seen || last_fetch_seen);
      line = hit_line;
    end
    else
    begin
      check_flag("fetch on miss", 1'b1, last_fetch_seen);
      check_address("fetch address", {t, {TAG_LSB{1'b0}}}, last_fetch_address);
      check_flag("write-back on miss", predict_wb, last_wb_seen);
      if (predict_wb)
      begin
        check_address("write-back address", wb_address, last_wb_address);
        check_line("write-back line", wb_line, last_wb_line);
      end
      model_tag[line] = t;
      model_valid[line] = 1'b1;
      model_dirty[line] = 1'b0;
    end
    touch_model(line);

    idx = word_index(a);
    sel = int'(a[WORD_OFFSET_LSB-1:0]);
    if (acc_op == OP_WRITE)
    begin
      model_dirty[line] = 1'b1;
      if (acc_byte)
      begin
        shadow_mem[idx][sel*8 +: 8] = d[7:0];
      end
      else
      begin
        shadow_mem[idx] = d;
      end
    end
    else
    begin
      expected = acc_byte ? {24'b0, shadow_mem[idx][sel*8 +: 8]} : shadow_mem[idx];
      check_word("data_out", expected, last_data);
    end
  endtask

  task automatic first_read_after_reset();
    test_name = "reset_and_first_read";
    @(negedge clk);
    check_flag("data_ready after reset", 1'b0, data_ready);
    check_flag("mem_enable after reset", 1'b0, mem_enable);
    run_access(OP_READ, 1'b0, 32'h0000_0008, '0);
    check_flag("first read fetches", 1'b1, last_fetch_seen);
    check_word("pattern word", pattern_at(32'h0000_0008), last_data);
  endtask

  task automatic repeat_read_hits();
    test_name = "hit_latency";
    run_access(OP_READ, 1'b0, 32'h0000_0004, '0);
    check_count("repeat read latency", 1, last_latency);
    check_flag("mem_enable on repeat read", 1'b0, last_fetch_seen || last_wb_seen);
  endtask

  task automatic byte_and_word_merge();
    test_name = "write_merge";
    run_access(OP_WRITE, 1'b1, 32'h0000_0021, 32'h0000_00ab);
    check_flag("byte write allocates", 1'b1, last_fetch_seen);
    run_access(OP_READ, 1'b0, 32'h0000_0020, '0);
    check_word("merged byte in word", (pattern_at(32'h0000_0020) & 32'hffff_00ff) | 32'h0000_ab00,
               last_data);
    run_access(OP_WRITE, 1'b0, 32'h0000_0024, 32'h1234_5678);
    run_access(OP_WRITE, 1'b1, 32'h0000_0027, 32'h0000_00cd);
    run_access(OP_READ, 1'b1, 32'h0000_0027, '0);
    check_word("byte read 0x27", 32'h0000_00cd, last_data);
    run_access(OP_READ, 1'b1, 32'h0000_0021, '0);
    check_word("byte read 0x21", 32'h0000_00ab, last_data);
    run_access(OP_READ, 1'b0, 32'h0000_0024, '0);
    check_word("merged word 0x24", 32'hcd34_5678, last_data);
  endtask

  task automatic lru_eviction();
    line_u expected;
    test_name = "lru_eviction";
    for (int i = 0; i < NUM_LINES; i++)
    begin
      run_access(OP_WRITE, 1'b0, 32'h0000_0100 + 32'(i * 16), 32'ha000_0000 + 32'(i));
    end
    // Line 0x100 becomes newest, so 0x110 is now the oldest
    run_access(OP_READ, 1'b0, 32'h0000_0100, '0);
    check_flag("re-touch hits", 1'b0, last_fetch_seen);
    run_access(OP_READ, 1'b0, 32'h0000_0100 + 32'(NUM_LINES * 16), '0);
    check_flag("write-back seen", 1'b1, last_wb_seen);
    check_address("victim address", 32'h0000_0110, last_wb_address);
    expected.words[0] = 32'ha000_0001;
    for (int k = 1; k < WORDS_PER_LINE; k++)
    begin
      expected.words[k] = pattern_at(32'h0000_0110 + 32'(k * 4));
    end
    check_line("victim line", expected, last_wb_line);
    run_access(OP_READ, 1'b0, 32'h0000_0110, '0);
    check_flag("evicted line refetched", 1'b1, last_fetch_seen);
    check_word("evicted word", 32'ha000_0001, last_data);
  endtask

  task automatic random_traffic();
    logic [ADDRESS_WIDTH-1:0] a;
    logic is_byte;
    logic is_read;
    test_name = "random_traffic";
    for (int n = 0; n < RANDOM_ACCESSES; n++)
    begin
      is_byte = 1'($urandom_range(1));
      is_read = 1'($urandom_range(1));
      a = 32'($urandom_range(RANDOM_LINES - 1) * 16 + $urandom_range(3) * 4);
      if (is_byte)
      begin
        a = a + 32'($urandom_range(3));
      end
      run_access(is_read ? OP_READ : OP_WRITE, is_byte, a, word_t'($urandom));
    end
  endtask

  initial
  begin
    reset = 1'b1;
    access = 1'b0;
    op = OP_READ;
    byte_op = 1'b0;
    address = '0;
    data_in = '0;
    value_errors = 0;
    handshake_errors = 0;
    void'($urandom(SEED));
    reset_model();
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    first_read_after_reset();
    repeat_read_hits();
    byte_and_word_merge();
    lru_eviction();
    random_traffic();

    $display("Finished with %0d value errors, %0d handshake errors and %0d assertion failures",
             value_errors, handshake_errors, uut.checks.failures);
    if (value_errors == 0 && handshake_errors == 0 && uut.checks.failures == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* line_cache.f */
common/cache_pkg.sv
cache/cache_tag_match.sv
cache/cache_lru.sv
cache/cache_core.sv
logic/line_memory.sv
logic/cache_system.sv
tests/cache_system_assertions.sv
tests/cache_system_tb.sv

/* Bender.yml */
package:
  name: line_cache

sources:
  - files:
      - common/cache_pkg.sv
      - cache/cache_tag_match.sv
      - cache/cache_lru.sv
      - cache/cache_core.sv
      - logic/line_memory.sv
      - logic/cache_system.sv
  - target: test
    files:
      - tests/cache_system_assertions.sv
      - tests/cache_system_tb.sv
